// File: rtl/ntt_params.svh
// Modulus, coefficient and memory widths, polynomial size and pipeline depths
`ifndef NTT_PARAMS_SVH
`define NTT_PARAMS_SVH

// ====================
// Arithmetic
// ====================

// q = 2^23 - 2^13 + 1
`define MLDSA_Q 23'd8380417
`define COEFF_W 23

// Stored field per coefficient, top bit always zero
`define REG_SIZE 24

// ====================
// Memory layout
// ====================
`define COEFF_PER_CLK 4
`define MEM_DATA_W (`COEFF_PER_CLK * `REG_SIZE)
`define MEM_ADDR_W 15
`define POLY_WORDS 64

// ====================
// Pipeline depths
// ====================

// Read request to matching write request
`define PWO_LAT 5
`define LANE_LAT 3

`endif

// File: rtl/ntt_mem_pkg.sv
// Memory command encoding, word address, request struct and raw memory word
`include "ntt_params.svh"

package ntt_mem_pkg;

    // ====================
    // Request fields
    // ====================

    // All-zero value must stay RW_IDLE, delay lines reset to it
    typedef enum logic [1:0] {
        RW_IDLE  = 2'b00,
        RW_READ  = 2'b01,
        RW_WRITE = 2'b10
    } rw_cmd_e;

    typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

    typedef struct packed {
        rw_cmd_e   rd_wr_en;
        mem_addr_t addr;
    } mem_if_t;

    // Four 24-bit fields, lane 0 in the low bits
    typedef logic [`MEM_DATA_W-1:0] mem_word_t;

endpackage

// File: rtl/pwo_arith_pkg.sv
// Pointwise operation modes, coefficient and word types, lane operand struct
`include "ntt_params.svh"

package pwo_arith_pkg;

    // ====================
    // Operations
    // ====================

    // pwm multiplies, pwa adds, pws subtracts
    typedef enum logic [1:0] {
        pwm = 2'd0,
        pwa = 2'd1,
        pws = 2'd2
    } pwo_mode_e;

    // ====================
    // Data
    // ====================

    typedef logic [`COEFF_W-1:0] coeff_t;

    // Operands for one lane, c_old is zero unless accumulating
    typedef struct packed {
        coeff_t a;
        coeff_t b;
        coeff_t c_old;
    } lane_ops_t;

    // One result word without the padding bits
    typedef coeff_t [`COEFF_PER_CLK-1:0] pwo_word_t;

endpackage

// File: rtl/pwo_delay_line.sv
// Fixed-depth shift register with a configurable payload type
`timescale 1ns/1ps

module pwo_delay_line #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     reset_n,
    input  payload_t d_i,
    output payload_t q_o
);

    payload_t stage_q [DEPTH];

    // Stage 0 takes the input, each later stage takes its neighbour
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= d_i;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign q_o = stage_q[DEPTH-1];

endmodule

// File: rtl/pwo_ctrl.sv
// Pointwise sequencer: operation latch, read address issue, write request delay, busy and done
`timescale 1ns/1ps
`include "ntt_params.svh"

module pwo_ctrl (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     ntt_enable_i,
    input  pwo_arith_pkg::pwo_mode_e mode_i,
    input  logic                     accumulate_i,
    input  ntt_mem_pkg::mem_addr_t   a_base_i,
    input  ntt_mem_pkg::mem_addr_t   b_base_i,
    input  ntt_mem_pkg::mem_addr_t   c_base_i,
    output ntt_mem_pkg::mem_if_t     a_rd_req_o,
    output ntt_mem_pkg::mem_if_t     b_rd_req_o,
    output ntt_mem_pkg::mem_if_t     c_rd_req_o,
    output ntt_mem_pkg::mem_if_t     c_wr_req_o,
    output pwo_arith_pkg::pwo_mode_e op_mode_o,
    output logic                     op_acc_o,
    output logic                     busy_o,
    output logic                     done_o
);

    localparam int CNT_W = $clog2(`POLY_WORDS);

    logic                     busy_q;
    logic                     rd_active_q;
    logic                     done_q;
    logic [CNT_W-1:0]         rd_cnt_q;
    pwo_arith_pkg::pwo_mode_e mode_q;
    logic                     acc_q;
    ntt_mem_pkg::mem_addr_t   a_base_q;
    ntt_mem_pkg::mem_addr_t   b_base_q;
    ntt_mem_pkg::mem_addr_t   c_base_q;
    ntt_mem_pkg::mem_addr_t   rd_offset;
    ntt_mem_pkg::mem_if_t     wr_req_now;
    ntt_mem_pkg::mem_if_t     wr_req_dly;
    logic                     start;
    logic                     last_rd;
    logic                     last_wr;

    // Start pulses are dropped while a run is in progress
    assign start   = ntt_enable_i & ~busy_q;
    assign last_rd = rd_active_q & (rd_cnt_q == CNT_W'(`POLY_WORDS - 1));
    assign last_wr = (wr_req_dly.rd_wr_en == ntt_mem_pkg::RW_WRITE) &&
                     (wr_req_dly.addr == c_base_q + ntt_mem_pkg::mem_addr_t'(`POLY_WORDS - 1));

    // ====================
    // Sequencer state
    // ====================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_q      <= 1'b0;
            rd_active_q <= 1'b0;
            done_q      <= 1'b0;
            rd_cnt_q    <= '0;
            mode_q      <= pwo_arith_pkg::pwm;
            acc_q       <= 1'b0;
            a_base_q    <= '0;
            b_base_q    <= '0;
            c_base_q    <= '0;
        end else begin
            done_q <= last_wr;
            if (start) begin
                busy_q      <= 1'b1;
                rd_active_q <= 1'b1;
                rd_cnt_q    <= '0;
                mode_q      <= mode_i;
                // Accumulate only means something for multiply
                acc_q       <= accumulate_i & (mode_i == pwo_arith_pkg::pwm);
                a_base_q    <= a_base_i;
                b_base_q    <= b_base_i;
                c_base_q    <= c_base_i;
            end else begin
                if (rd_active_q) begin
                    rd_cnt_q <= rd_cnt_q + 1'b1;
                end
                if (last_rd) begin
                    rd_active_q <= 1'b0;
                end
                if (last_wr) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    // ====================
    // Requests
    // ====================
    always_comb begin
        rd_offset  = ntt_mem_pkg::mem_addr_t'(rd_cnt_q);
        a_rd_req_o = '0;
        b_rd_req_o = '0;
        c_rd_req_o = '0;
        wr_req_now = '0;
        if (rd_active_q) begin
            a_rd_req_o.rd_wr_en = ntt_mem_pkg::RW_READ;
            a_rd_req_o.addr     = a_base_q + rd_offset;
            b_rd_req_o.rd_wr_en = ntt_mem_pkg::RW_READ;
            b_rd_req_o.addr     = b_base_q + rd_offset;
            if (acc_q) begin
                c_rd_req_o.rd_wr_en = ntt_mem_pkg::RW_READ;
                c_rd_req_o.addr     = c_base_q + rd_offset;
            end
            // Write for the same word, released once the lanes are done with it
            wr_req_now.rd_wr_en = ntt_mem_pkg::RW_WRITE;
            wr_req_now.addr     = c_base_q + rd_offset;
        end
    end

    pwo_delay_line #(
        .payload_t (ntt_mem_pkg::mem_if_t),
        .DEPTH     (`PWO_LAT)
    ) u_wr_dly (
        .clk     (clk),
        .reset_n (reset_n),
        .d_i     (wr_req_now),
        .q_o     (wr_req_dly)
    );

    assign c_wr_req_o = wr_req_dly;
    assign op_mode_o  = mode_q;
    assign op_acc_o   = acc_q;
    assign busy_o     = busy_q;
    assign done_o     = done_q;

endmodule

// File: rtl/mldsa_mod_mult.sv
// Two-stage modular multiplier for q = 2^23 - 2^13 + 1
`timescale 1ns/1ps
`include "ntt_params.svh"

module mldsa_mod_mult (
    input  logic                  clk,
    input  logic                  reset_n,
    input  pwo_arith_pkg::coeff_t a_i,
    input  pwo_arith_pkg::coeff_t b_i,
    output pwo_arith_pkg::coeff_t p_o
);

    localparam int PROD_W = 2 * `COEFF_W;

    logic [PROD_W-1:0]     prod_q;
    logic [36:0]           fold1;
    logic [27:0]           fold2;
    logic [23:0]           fold3;
    logic [23:0]           red;
    pwo_arith_pkg::coeff_t p_q;

    // ====================
    // Stage 1: product
    // ====================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q <= '0;
        end else begin
            prod_q <= a_i * b_i;
        end
    end

    // ====================
    // Stage 2: folding
    // ====================

    // Each pass replaces h * 2^23 by h * (2^13 - 1)
    assign fold1 = 37'({prod_q[45:23], 13'd0}) - 37'(prod_q[45:23]) + 37'(prod_q[22:0]);
    assign fold2 = 28'({fold1[36:23], 13'd0}) - 28'(fold1[36:23]) + 28'(fold1[22:0]);
    // High part is at most 16 here, so the result stays below 2q
    assign fold3 = 24'({fold2[27:23], 13'd0}) - 24'(fold2[27:23]) + 24'(fold2[22:0]);
    assign red   = (fold3 >= 24'(`MLDSA_Q)) ? fold3 - 24'(`MLDSA_Q) : fold3;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            p_q <= '0;
        end else begin
            p_q <= red[`COEFF_W-1:0];
        end
    end

    assign p_o = p_q;

endmodule

// File: rtl/pwo_lane.sv
// One coefficient lane: modular multiply-accumulate, add or subtract
`timescale 1ns/1ps
`include "ntt_params.svh"

module pwo_lane (
    input  logic                     clk,
    input  logic                     reset_n,
    input  pwo_arith_pkg::pwo_mode_e op_mode_i,
    input  logic                     op_acc_i,
    input  pwo_arith_pkg::lane_ops_t ops_i,
    output pwo_arith_pkg::coeff_t    r_o
);

    pwo_arith_pkg::lane_ops_t ops_d;
    pwo_arith_pkg::coeff_t    prod;
    pwo_arith_pkg::coeff_t    r_q;
    logic                     pwm_mode_q;
    logic                     pwa_mode_q;
    logic                     pws_mode_q;
    logic [`REG_SIZE-1:0]     add_x;
    logic [`REG_SIZE-1:0]     add_y;
    logic [`REG_SIZE-1:0]     add_sum;
    logic [`REG_SIZE-1:0]     sub_diff;
    logic [`REG_SIZE-1:0]     add_res;
    logic [`REG_SIZE-1:0]     sub_res;

    // One-hot mode flags, stable for a whole run
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pwm_mode_q <= 1'b0;
            pwa_mode_q <= 1'b0;
            pws_mode_q <= 1'b0;
        end else begin
            pwm_mode_q <= (op_mode_i == pwo_arith_pkg::pwm);
            pwa_mode_q <= (op_mode_i == pwo_arith_pkg::pwa);
            pws_mode_q <= (op_mode_i == pwo_arith_pkg::pws);
        end
    end

    mldsa_mod_mult u_mult (
        .clk     (clk),
        .reset_n (reset_n),
        .a_i     (ops_i.a),
        .b_i     (ops_i.b),
        .p_o     (prod)
    );

    // Operands travel next to the multiplier
    pwo_delay_line #(
        .payload_t (pwo_arith_pkg::lane_ops_t),
        .DEPTH     (`LANE_LAT - 1)
    ) u_ops_dly (
        .clk     (clk),
        .reset_n (reset_n),
        .d_i     (ops_i),
        .q_o     (ops_d)
    );

    // Shared adder: product + c_old for pwm, a + b for pwa
    assign add_x    = pwm_mode_q ? {1'b0, prod} : {1'b0, ops_d.a};
    assign add_y    = pwm_mode_q ? (op_acc_i ? {1'b0, ops_d.c_old} : '0) : {1'b0, ops_d.b};
    assign add_sum  = add_x + add_y;
    assign add_res  = (add_sum >= `REG_SIZE'(`MLDSA_Q)) ? add_sum - `REG_SIZE'(`MLDSA_Q) : add_sum;

    // Borrow out of a - b means add q back
    assign sub_diff = {1'b0, ops_d.a} - {1'b0, ops_d.b};
    assign sub_res  = sub_diff[`REG_SIZE-1] ? sub_diff + `REG_SIZE'(`MLDSA_Q) : sub_diff;

    always_ff @(posedge clk) begin
        if (pwm_mode_q || pwa_mode_q) begin
            r_q <= add_res[`COEFF_W-1:0];
        end else if (pws_mode_q) begin
            r_q <= sub_res[`COEFF_W-1:0];
        end else begin
            r_q <= '0;
        end
    end

    assign r_o = r_q;

endmodule

// File: rtl/pwo_top.sv
// Pointwise engine top: sequencer, read data registers, four lanes and write data packing
`timescale 1ns/1ps
`include "ntt_params.svh"

module pwo_top (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     ntt_enable_i,
    input  pwo_arith_pkg::pwo_mode_e mode_i,
    input  logic                     accumulate_i,
    input  ntt_mem_pkg::mem_addr_t   a_base_i,
    input  ntt_mem_pkg::mem_addr_t   b_base_i,
    input  ntt_mem_pkg::mem_addr_t   c_base_i,
    input  ntt_mem_pkg::mem_word_t   a_rd_data_i,
    input  ntt_mem_pkg::mem_word_t   b_rd_data_i,
    input  ntt_mem_pkg::mem_word_t   c_rd_data_i,
    output ntt_mem_pkg::mem_if_t     a_rd_req_o,
    output ntt_mem_pkg::mem_if_t     b_rd_req_o,
    output ntt_mem_pkg::mem_if_t     c_rd_req_o,
    output ntt_mem_pkg::mem_if_t     c_wr_req_o,
    output ntt_mem_pkg::mem_word_t   c_wr_data_o,
    output logic                     busy_o,
    output logic                     done_o
);

    pwo_arith_pkg::pwo_mode_e op_mode;
    logic                     op_acc;
    ntt_mem_pkg::mem_word_t   a_word_q;
    ntt_mem_pkg::mem_word_t   b_word_q;
    ntt_mem_pkg::mem_word_t   c_word_q;
    pwo_arith_pkg::lane_ops_t lane_ops [`COEFF_PER_CLK];
    pwo_arith_pkg::pwo_word_t lane_res;

    // ====================
    // Sequencer
    // ====================
    pwo_ctrl u_ctrl (
        .clk          (clk),
        .reset_n      (reset_n),
        .ntt_enable_i (ntt_enable_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .a_base_i     (a_base_i),
        .b_base_i     (b_base_i),
        .c_base_i     (c_base_i),
        .a_rd_req_o   (a_rd_req_o),
        .b_rd_req_o   (b_rd_req_o),
        .c_rd_req_o   (c_rd_req_o),
        .c_wr_req_o   (c_wr_req_o),
        .op_mode_o    (op_mode),
        .op_acc_o     (op_acc),
        .busy_o       (busy_o),
        .done_o       (done_o)
    );

    // Memory data is flopped once before it reaches the lanes
    always_ff @(posedge clk) begin
        a_word_q <= a_rd_data_i;
        b_word_q <= b_rd_data_i;
        c_word_q <= c_rd_data_i;
    end

    // ====================
    // Lanes
    // ====================
    for (genvar i = 0; i < `COEFF_PER_CLK; i++) begin : g_lane
        // Drop the padding bit of each 24-bit field
        assign lane_ops[i] = '{
            a:     a_word_q[i*`REG_SIZE +: `COEFF_W],
            b:     b_word_q[i*`REG_SIZE +: `COEFF_W],
            c_old: op_acc ? c_word_q[i*`REG_SIZE +: `COEFF_W] : '0
        };

        pwo_lane u_lane (
            .clk       (clk),
            .reset_n   (reset_n),
            .op_mode_i (op_mode),
            .op_acc_i  (op_acc),
            .ops_i     (lane_ops[i]),
            .r_o       (lane_res[i])
        );

        assign c_wr_data_o[i*`REG_SIZE +: `REG_SIZE] =
            {{(`REG_SIZE - `COEFF_W){1'b0}}, lane_res[i]};
    end

endmodule

// File: verif/pwo_tb_clkgen.sv
// Free-running testbench clock source
`timescale 1ns/1ps

module pwo_tb_clkgen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk_o
);

    // Starts low so the first rising edge is half a period in
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

endmodule

// File: verif/pwo_mem_model.sv
// Behavioral word memory with one-cycle read latency, a write port and direct load and peek access
`timescale 1ns/1ps
`include "ntt_params.svh"

module pwo_mem_model #(
    parameter int WORDS = `POLY_WORDS
) (
    input  logic                   clk,
    input  ntt_mem_pkg::mem_if_t   rd_req_i,
    output ntt_mem_pkg::mem_word_t rd_data_o,
    input  ntt_mem_pkg::mem_if_t   wr_req_i,
    input  ntt_mem_pkg::mem_word_t wr_data_i
);

    ntt_mem_pkg::mem_word_t mem [WORDS];

    initial begin
        rd_data_o = '0;
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // Read first, so a read and a write of one word in one cycle returns the old word
    always @(posedge clk) begin
        if (rd_req_i.rd_wr_en == ntt_mem_pkg::RW_READ && int'(rd_req_i.addr) < WORDS) begin
            rd_data_o <= mem[rd_req_i.addr];
        end
        if (wr_req_i.rd_wr_en == ntt_mem_pkg::RW_WRITE && int'(wr_req_i.addr) < WORDS) begin
            mem[wr_req_i.addr] = wr_data_i;
        end
    end

    task automatic load_word(input int addr, input ntt_mem_pkg::mem_word_t data);
        mem[addr] = data;
    endtask

    function automatic ntt_mem_pkg::mem_word_t peek_word(input int addr);
        return mem[addr];
    endfunction

endmodule

// File: verif/pwo_tb.sv
// Pointwise engine testbench with test table, LCG operands, reference model, checks and timeout
`timescale 1ns/1ps
`include "ntt_params.svh"

module pwo_tb;

    localparam int MEM_WORDS      = 256;
    localparam int N_TESTS        = 6;
    localparam int TIMEOUT_CYCLES = N_TESTS * (`POLY_WORDS + `PWO_LAT + 10) + 100;
    localparam logic [31:0] LCG_SEED = 32'h0b1a_51c2;
    localparam pwo_arith_pkg::coeff_t COEFF_MAX = `MLDSA_Q - 23'd1;

    typedef enum logic {FILL_RANDOM, FILL_MAX} fill_e;

    typedef struct packed {
        pwo_arith_pkg::pwo_mode_e mode;
        logic                     acc;
        ntt_mem_pkg::mem_addr_t   a_base;
        ntt_mem_pkg::mem_addr_t   b_base;
        ntt_mem_pkg::mem_addr_t   c_base;
        fill_e                    fill;
    } test_row_t;

    // ====================
    // Test table
    // ====================

    // Multiply without accumulate follows an accumulate run so stale C data sits on the read port
    localparam test_row_t TESTS [N_TESTS] = '{
        '{pwo_arith_pkg::pwm, 1'b1, 15'd0,  15'd64,  15'd128, FILL_RANDOM},
        '{pwo_arith_pkg::pwm, 1'b0, 15'd16, 15'd100, 15'd40,  FILL_RANDOM},
        '{pwo_arith_pkg::pwa, 1'b0, 15'd5,  15'd70,  15'd150, FILL_RANDOM},
        '{pwo_arith_pkg::pwa, 1'b0, 15'd0,  15'd64,  15'd128, FILL_MAX},
        '{pwo_arith_pkg::pws, 1'b1, 15'd30, 15'd90,  15'd160, FILL_RANDOM},
        '{pwo_arith_pkg::pwm, 1'b1, 15'd10, 15'd80,  15'd170, FILL_MAX}
    };

    logic                     clk;
    logic                     reset_n;
    logic                     ntt_enable;
    pwo_arith_pkg::pwo_mode_e mode;
    logic                     accumulate;
    ntt_mem_pkg::mem_addr_t   a_base;
    ntt_mem_pkg::mem_addr_t   b_base;
    ntt_mem_pkg::mem_addr_t   c_base;
    ntt_mem_pkg::mem_word_t   a_rd_data;
    ntt_mem_pkg::mem_word_t   b_rd_data;
    ntt_mem_pkg::mem_word_t   c_rd_data;
    ntt_mem_pkg::mem_word_t   c_wr_data;
    ntt_mem_pkg::mem_if_t     a_rd_req;
    ntt_mem_pkg::mem_if_t     b_rd_req;
    ntt_mem_pkg::mem_if_t     c_rd_req;
    ntt_mem_pkg::mem_if_t     c_wr_req;
    ntt_mem_pkg::mem_if_t     no_req;
    ntt_mem_pkg::mem_word_t   no_data;
    logic                     busy;
    logic                     done;

    logic [31:0]              lcg_state;
    int                       err_cnt;
    int                       failed_tests;
    int unsigned              cycle_cnt = 0;
    ntt_mem_pkg::mem_word_t   a_img [MEM_WORDS];
    ntt_mem_pkg::mem_word_t   b_img [MEM_WORDS];
    ntt_mem_pkg::mem_word_t   c_img [MEM_WORDS];

    assign no_req  = '0;
    assign no_data = '0;

    pwo_tb_clkgen #(.PERIOD_NS(100)) i_clkgen (.clk_o(clk));

    pwo_top i_pwo_top (
        .clk          (clk),
        .reset_n      (reset_n),
        .ntt_enable_i (ntt_enable),
        .mode_i       (mode),
        .accumulate_i (accumulate),
        .a_base_i     (a_base),
        .b_base_i     (b_base),
        .c_base_i     (c_base),
        .a_rd_data_i  (a_rd_data),
        .b_rd_data_i  (b_rd_data),
        .c_rd_data_i  (c_rd_data),
        .a_rd_req_o   (a_rd_req),
        .b_rd_req_o   (b_rd_req),
        .c_rd_req_o   (c_rd_req),
        .c_wr_req_o   (c_wr_req),
        .c_wr_data_o  (c_wr_data),
        .busy_o       (busy),
        .done_o       (done)
    );

    pwo_mem_model #(.WORDS(MEM_WORDS)) i_mem_a (
        .clk(clk), .rd_req_i(a_rd_req), .rd_data_o(a_rd_data),
        .wr_req_i(no_req), .wr_data_i(no_data)
    );
    pwo_mem_model #(.WORDS(MEM_WORDS)) i_mem_b (
        .clk(clk), .rd_req_i(b_rd_req), .rd_data_o(b_rd_data),
        .wr_req_i(no_req), .wr_data_i(no_data)
    );
    pwo_mem_model #(.WORDS(MEM_WORDS)) i_mem_c (
        .clk(clk), .rd_req_i(c_rd_req), .rd_data_o(c_rd_data),
        .wr_req_i(c_wr_req), .wr_data_i(c_wr_data)
    );

    // ====================
    // Helpers and model
    // ====================
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic pwo_arith_pkg::coeff_t next_coeff();
        lcg_state = lcg_next(lcg_state);
        return pwo_arith_pkg::coeff_t'(lcg_state % 32'(`MLDSA_Q));
    endfunction

    function automatic ntt_mem_pkg::mem_word_t pack_word(input pwo_arith_pkg::pwo_word_t c);
        ntt_mem_pkg::mem_word_t w;
        w = '0;
        for (int l = 0; l < `COEFF_PER_CLK; l++) begin
            w[l*`REG_SIZE +: `COEFF_W] = c[l];
        end
        return w;
    endfunction

    function automatic pwo_arith_pkg::coeff_t coeff_at(input ntt_mem_pkg::mem_word_t w,
                                                       input int lane);
        return w[lane*`REG_SIZE +: `COEFF_W];
    endfunction

    // Plain integer arithmetic where accumulate only counts for pwm
    function automatic pwo_arith_pkg::coeff_t expected_coeff(
        input pwo_arith_pkg::pwo_mode_e m, input logic acc,
        input pwo_arith_pkg::coeff_t a, input pwo_arith_pkg::coeff_t b,
        input pwo_arith_pkg::coeff_t c_old);
        longint q;
        longint r;
        q = longint'(`MLDSA_Q);
        case (m)
            pwo_arith_pkg::pwm: r = (longint'(a) * longint'(b) + (acc ? longint'(c_old) : 0)) % q;
            pwo_arith_pkg::pwa: r = (longint'(a) + longint'(b)) % q;
            pwo_arith_pkg::pws: r = (longint'(a) - longint'(b) + q) % q;
            default:            r = 0;
        endcase
        return pwo_arith_pkg::coeff_t'(r);
    endfunction

    task automatic check(input logic ok, input string what);
        assert (ok) else begin
            $display("ERROR at %0t: %s", $time, what);
            err_cnt++;
        end
    endtask

    task automatic load_memories(input test_row_t row);
        pwo_arith_pkg::pwo_word_t wa;
        pwo_arith_pkg::pwo_word_t wb;
        pwo_arith_pkg::pwo_word_t wc;
        for (int addr = 0; addr < MEM_WORDS; addr++) begin
            for (int l = 0; l < `COEFF_PER_CLK; l++) begin
                wa[l] = (row.fill == FILL_MAX) ? COEFF_MAX : next_coeff();
                wb[l] = (row.fill == FILL_MAX) ? COEFF_MAX : next_coeff();
                wc[l] = next_coeff();
            end
            a_img[addr] = pack_word(wa);
            b_img[addr] = pack_word(wb);
            c_img[addr] = pack_word(wc);
            i_mem_a.load_word(addr, a_img[addr]);
            i_mem_b.load_word(addr, b_img[addr]);
            i_mem_c.load_word(addr, c_img[addr]);
        end
    endtask

    // ====================
    // One run with protocol monitor
    // ====================
    task automatic run_test(input test_row_t row);
        int                     rd_cyc [`POLY_WORDS];
        int                     cyc;
        int                     rd_cnt;
        int                     wr_cnt;
        int                     last_wr;
        int                     k;
        logic                   c_reads;
        ntt_mem_pkg::mem_addr_t offs;
        c_reads = row.acc && (row.mode == pwo_arith_pkg::pwm);
        for (int i = 0; i < `POLY_WORDS; i++) begin
            rd_cyc[i] = -100;
        end
        rd_cnt  = 0;
        wr_cnt  = 0;
        last_wr = -100;
        mode       = row.mode;
        accumulate = row.acc;
        a_base     = row.a_base;
        b_base     = row.b_base;
        c_base     = row.c_base;
        ntt_enable = 1'b1;
        @(negedge clk);
        cyc = 0;
        while (done !== 1'b1) begin
            check(busy === 1'b1, $sformatf("busy_o low in run cycle %0d", cyc));
            if (a_rd_req.rd_wr_en == ntt_mem_pkg::RW_READ) begin
                offs = a_rd_req.addr - row.a_base;
                k    = int'(offs);
                check(k == rd_cnt, $sformatf("A read %0d at word offset %0d", rd_cnt, k));
                check(b_rd_req.rd_wr_en == ntt_mem_pkg::RW_READ &&
                      b_rd_req.addr == row.b_base + offs, "B read does not match A read");
                if (c_reads) begin
                    check(c_rd_req.rd_wr_en == ntt_mem_pkg::RW_READ &&
                          c_rd_req.addr == row.c_base + offs, "C read does not match A read");
                end else begin
                    check(c_rd_req.rd_wr_en == ntt_mem_pkg::RW_IDLE, "C read without accumulate");
                end
                if (k < `POLY_WORDS) begin
                    rd_cyc[k] = cyc;
                end
                rd_cnt++;
            end else begin
                check(b_rd_req.rd_wr_en == ntt_mem_pkg::RW_IDLE &&
                      c_rd_req.rd_wr_en == ntt_mem_pkg::RW_IDLE, "B or C read without A read");
            end
            if (c_wr_req.rd_wr_en == ntt_mem_pkg::RW_WRITE) begin
                offs = c_wr_req.addr - row.c_base;
                k    = int'(offs);
                if (k < `POLY_WORDS) begin
                    check(cyc == rd_cyc[k] + `PWO_LAT, $sformatf(
                          "word %0d written in cycle %0d, read in cycle %0d", k, cyc, rd_cyc[k]));
                end else begin
                    check(1'b0, $sformatf("write to address %0d outside the result", c_wr_req.addr));
                end
                wr_cnt++;
                last_wr = cyc;
            end
            // A second start while busy with other settings must change nothing
            ntt_enable = (cyc == 20);
            if (cyc == 20) begin
                mode       = pwo_arith_pkg::pws;
                accumulate = ~row.acc;
                c_base     = '0;
            end
            @(negedge clk);
            cyc++;
        end
        check(rd_cnt == `POLY_WORDS, $sformatf("%0d reads instead of 64", rd_cnt));
        check(wr_cnt == `POLY_WORDS, $sformatf("%0d writes instead of 64", wr_cnt));
        check(last_wr == cyc - 1, "done_o not on the edge after the last write");
        check(busy === 1'b0, "busy_o still high together with done_o");
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            check(done === 1'b0, "done_o high for more than one cycle");
            check(c_wr_req.rd_wr_en == ntt_mem_pkg::RW_IDLE &&
                  a_rd_req.rd_wr_en == ntt_mem_pkg::RW_IDLE, "request after the run ended");
        end
    endtask

    task automatic check_results(input test_row_t row);
        ntt_mem_pkg::mem_word_t got;
        ntt_mem_pkg::mem_addr_t offs;
        pwo_arith_pkg::coeff_t  exp_c;
        int                     k;
        for (int addr = 0; addr < MEM_WORDS; addr++) begin
            got  = i_mem_c.peek_word(addr);
            offs = ntt_mem_pkg::mem_addr_t'(addr) - row.c_base;
            k    = int'(offs);
            if (k < `POLY_WORDS) begin
                for (int l = 0; l < `COEFF_PER_CLK; l++) begin
                    exp_c = expected_coeff(row.mode, row.acc,
                                           coeff_at(a_img[int'(row.a_base) + k], l),
                                           coeff_at(b_img[int'(row.b_base) + k], l),
                                           coeff_at(c_img[addr], l));
                    check(coeff_at(got, l) == exp_c, $sformatf(
                          "word %0d lane %0d is %0d, expected %0d",
                          addr, l, coeff_at(got, l), exp_c));
                    check(got[l*`REG_SIZE + `COEFF_W] == 1'b0,
                          $sformatf("word %0d lane %0d has its top bit set", addr, l));
                end
            end else begin
                check(got == c_img[addr], $sformatf("word %0d outside the result changed", addr));
            end
        end
    endtask

    // ====================
    // Watchdog
    // ====================
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        int err_before;
        reset_n      = 1'b0;
        ntt_enable   = 1'b0;
        mode         = pwo_arith_pkg::pwm;
        accumulate   = 1'b0;
        a_base       = '0;
        b_base       = '0;
        c_base       = '0;
        lcg_state    = LCG_SEED;
        err_cnt      = 0;
        failed_tests = 0;
        repeat (8) @(negedge clk);
        check(busy === 1'b0 && done === 1'b0, "busy_o or done_o high in reset");
        check(a_rd_req == '0 && b_rd_req == '0 && c_rd_req == '0 && c_wr_req == '0,
              "request not idle in reset");
        reset_n = 1'b1;
        @(negedge clk);
        for (int t = 0; t < N_TESTS; t++) begin
            err_before = err_cnt;
            load_memories(TESTS[t]);
            run_test(TESTS[t]);
            check_results(TESTS[t]);
            if (err_cnt != err_before) begin
                failed_tests++;
            end
            $display("test %0d %s acc %0b %s: %s", t, TESTS[t].mode.name(), TESTS[t].acc,
                     TESTS[t].fill.name(), (err_cnt == err_before) ? "pass" : "fail");
        end
        $display("tests %0d, passed %0d, failed %0d, check errors %0d",
                 N_TESTS, N_TESTS - failed_tests, failed_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: pwo_top.f
+incdir+rtl
rtl/ntt_mem_pkg.sv
rtl/pwo_arith_pkg.sv
rtl/pwo_delay_line.sv
rtl/pwo_ctrl.sv
rtl/mldsa_mod_mult.sv
rtl/pwo_lane.sv
rtl/pwo_top.sv
verif/pwo_tb_clkgen.sv
verif/pwo_mem_model.sv
verif/pwo_tb.sv

// File: Makefile
# Verilator build and run of the pointwise engine testbench

TOP := pwo_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f pwo_top.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -qx "SIMULATION PASSED" $(LOG) || \
		(echo "Pass line not found in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
